// ==== build.f ====
+incdir+common
common/rvv_pkg.sv
hdl/rvv_issue.sv
hdl/rvv_vcfg.sv
hdl/rvv_vregs.sv
hdl/rvv_move_unit.sv
lsu/rvv_lsu.sv
hdl/rvv_coproc_top.sv
testbench/tb_rvv_mem.sv
testbench/tb_rvv.sv

// ==== common/rvv_params.svh ====
`ifndef RVV_PARAMS_SVH
`define RVV_PARAMS_SVH

// vector register width in bits
`define RVV_VLEN 128

// architectural vector registers
`define RVV_NUM_VREGS 32

`define RVV_XLEN 32 // scalar and memory word

// vl and element counters, enough for 128 elements
`define RVV_VL_W 9

`endif

// ==== common/rvv_pkg.sv ====
`include "rvv_params.svh"

package rvv_pkg;

	typedef logic [`RVV_VLEN-1:0] vreg_t;
	typedef logic [4:0]           vreg_addr_t;
	typedef logic [`RVV_XLEN-1:0] xword_t;
	typedef logic [`RVV_VL_W-1:0] vl_t;

	// same encoding as the vsew field of vtype
	typedef enum logic [2:0] {
		sew_8  = 3'b000,
		sew_16 = 3'b001,
		sew_32 = 3'b010
	} sew_e;

	typedef logic [2:0] lmul_t; // vlmul field, integer values only

	typedef enum logic [3:0] {
		op_none,
		op_vsetvli,
		op_vsetivli,
		op_vsetvl,
		op_vload,
		op_vstore,
		op_vmv_v,
		op_vmv_xs,
		op_vmv_sx
	} rvv_op_e;

	// operand kind of vmv.v.*
	typedef enum logic [1:0] {
		opnd_vv,
		opnd_vx,
		opnd_vi
	} opnd_e;

endpackage

// ==== hdl/rvv_coproc_top.sv ====
`timescale 1ns/1ps

module rvv_coproc_top import rvv_pkg::*; (
	input  logic       clk,
	input  logic       resetn,
	input  logic       pcpi_valid_i,
	input  xword_t     pcpi_insn_i,
	input  xword_t     pcpi_rs1_i,
	input  xword_t     pcpi_rs2_i,
	output logic       pcpi_ready_o,
	output logic       pcpi_wait_o,
	output logic       pcpi_wr_o,
	output xword_t     pcpi_rd_o,
	output logic       pcpi_is_rvv_o,
	input  xword_t     mem_rdata_i,
	input  logic       mem_done_i,
	output logic       mem_req_o,
	output logic       mem_we_o,
	output xword_t     mem_addr_o,
	output xword_t     mem_wdata_o,
	output logic [3:0] mem_strb_o
);
	rvv_op_e    op;
	opnd_e      opnd;
	logic       cfg_start, mv_start, lsu_start;
	logic       cfg_done, mv_done, lsu_done;
	logic       mv_wr;
	xword_t     mv_rd;
	vl_t        vl;
	sew_e       sew;
	lmul_t      lmul;
	vreg_addr_t mv_raddr, mv_waddr, lsu_raddr, lsu_waddr;
	vreg_t      mv_rdata, mv_wdata, lsu_rdata, lsu_wdata;
	logic       mv_we, lsu_we;

	rvv_issue i_issue (
		.clk(clk), .resetn(resetn),
		.pcpi_valid_i(pcpi_valid_i), .pcpi_insn_i(pcpi_insn_i),
		.pcpi_ready_o(pcpi_ready_o), .pcpi_wait_o(pcpi_wait_o),
		.pcpi_wr_o(pcpi_wr_o), .pcpi_rd_o(pcpi_rd_o), .pcpi_is_rvv_o(pcpi_is_rvv_o),
		.op_o(op), .opnd_o(opnd),
		.cfg_start_o(cfg_start), .mv_start_o(mv_start), .lsu_start_o(lsu_start),
		.cfg_done_i(cfg_done), .cfg_vl_i(vl),
		.mv_done_i(mv_done), .mv_wr_i(mv_wr), .mv_rd_i(mv_rd),
		.lsu_done_i(lsu_done)
	);

	rvv_vcfg i_vcfg (
		.clk(clk), .resetn(resetn), .start_i(cfg_start), .op_i(op),
		.insn_i(pcpi_insn_i), .rs1_i(pcpi_rs1_i), .rs2_i(pcpi_rs2_i),
		.done_o(cfg_done), .vl_o(vl), .sew_o(sew), .lmul_o(lmul)
	);

	rvv_vregs i_vregs (
		.clk(clk),
		.raddr_a_i(mv_raddr), .rdata_a_o(mv_rdata),
		.raddr_b_i(lsu_raddr), .rdata_b_o(lsu_rdata),
		.mv_we_i(mv_we), .mv_waddr_i(mv_waddr), .mv_wdata_i(mv_wdata),
		.lsu_we_i(lsu_we), .lsu_waddr_i(lsu_waddr), .lsu_wdata_i(lsu_wdata)
	);

	rvv_move_unit i_move (
		.clk(clk), .resetn(resetn), .start_i(mv_start), .op_i(op), .opnd_i(opnd),
		.insn_i(pcpi_insn_i), .rs1_i(pcpi_rs1_i),
		.vl_i(vl), .sew_i(sew), .lmul_i(lmul),
		.raddr_o(mv_raddr), .rdata_i(mv_rdata),
		.waddr_o(mv_waddr), .wdata_o(mv_wdata), .we_o(mv_we),
		.done_o(mv_done), .wr_o(mv_wr), .rd_o(mv_rd)
	);

	rvv_lsu i_lsu (
		.clk(clk), .resetn(resetn), .start_i(lsu_start), .op_i(op),
		.insn_i(pcpi_insn_i), .rs1_i(pcpi_rs1_i), .vl_i(vl),
		.raddr_o(lsu_raddr), .rdata_i(lsu_rdata),
		.waddr_o(lsu_waddr), .wdata_o(lsu_wdata), .we_o(lsu_we),
		.mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o), .mem_strb_o(mem_strb_o),
		.mem_rdata_i(mem_rdata_i), .mem_done_i(mem_done_i),
		.done_o(lsu_done)
	);

endmodule

// ==== hdl/rvv_issue.sv ====
`timescale 1ns/1ps

module rvv_issue import rvv_pkg::*; (
	input  logic    clk,
	input  logic    resetn,
	input  logic    pcpi_valid_i,
	input  xword_t  pcpi_insn_i,
	output logic    pcpi_ready_o,
	output logic    pcpi_wait_o,
	output logic    pcpi_wr_o,
	output xword_t  pcpi_rd_o,
	output logic    pcpi_is_rvv_o,
	output rvv_op_e op_o,
	output opnd_e   opnd_o,
	output logic    cfg_start_o,
	output logic    mv_start_o,
	output logic    lsu_start_o,
	input  logic    cfg_done_i,
	input  vl_t     cfg_vl_i,
	input  logic    mv_done_i,
	input  logic    mv_wr_i,
	input  xword_t  mv_rd_i,
	input  logic    lsu_done_i
);
	rvv_op_e dec_op;
	opnd_e   dec_opnd;
	logic    busy;
	logic    accept;
	logic    unit_done;

	always_comb begin
		dec_op = op_none;
		dec_opnd = opnd_vv;
		case (pcpi_insn_i[6:0])
			7'b1010111: begin
				if (pcpi_insn_i[14:12] == 3'b111) begin
					if (!pcpi_insn_i[31])
						dec_op = op_vsetvli;
					else if (pcpi_insn_i[31:30] == 2'b11)
						dec_op = op_vsetivli;
					else if (pcpi_insn_i[31:25] == 7'b1000000)
						dec_op = op_vsetvl;
				end else if (pcpi_insn_i[31:25] == 7'b0101111 && pcpi_insn_i[24:20] == 5'd0) begin
					// vmv.v.* is vmerge with vm set and vs2 = v0
					case (pcpi_insn_i[14:12])
						3'b000: dec_op = op_vmv_v;
						3'b100: begin
							dec_op = op_vmv_v;
							dec_opnd = opnd_vx;
						end
						3'b011: begin
							dec_op = op_vmv_v;
							dec_opnd = opnd_vi;
						end
						default: ;
					endcase
				end else if (pcpi_insn_i[31:25] == 7'b0100001) begin
					if (pcpi_insn_i[14:12] == 3'b010 && pcpi_insn_i[19:15] == 5'd0)
						dec_op = op_vmv_xs;
					else if (pcpi_insn_i[14:12] == 3'b110 && pcpi_insn_i[24:20] == 5'd0)
						dec_op = op_vmv_sx;
				end
			end
			7'b0000111, 7'b0100111: begin
				// unit stride only: nf 0, mew 0, mop 0, vm 1, lumop 0
				if (pcpi_insn_i[31:25] == 7'b0000001 && pcpi_insn_i[24:20] == 5'd0 &&
						pcpi_insn_i[14:12] inside {3'b000, 3'b101, 3'b110})
					dec_op = pcpi_insn_i[5] ? op_vstore : op_vload;
			end
			default: ;
		endcase
	end

	assign pcpi_is_rvv_o = (dec_op != op_none);
	assign pcpi_wait_o = busy;

	// no accept in the ready cycle, valid is still up then
	assign accept = pcpi_valid_i && pcpi_is_rvv_o && !busy && !pcpi_ready_o;
	assign unit_done = cfg_done_i | mv_done_i | lsu_done_i;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			op_o <= op_none;
			opnd_o <= opnd_vv;
			cfg_start_o <= 1'b0;
			mv_start_o <= 1'b0;
			lsu_start_o <= 1'b0;
			pcpi_ready_o <= 1'b0;
			pcpi_wr_o <= 1'b0;
		end else begin
			cfg_start_o <= 1'b0;
			mv_start_o <= 1'b0;
			lsu_start_o <= 1'b0;
			pcpi_ready_o <= 1'b0;
			pcpi_wr_o <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				op_o <= dec_op; // held until the next accept
				opnd_o <= dec_opnd;
				cfg_start_o <= dec_op inside {op_vsetvli, op_vsetivli, op_vsetvl};
				mv_start_o <= dec_op inside {op_vmv_v, op_vmv_xs, op_vmv_sx};
				lsu_start_o <= dec_op inside {op_vload, op_vstore};
			end
			if (unit_done) begin
				busy <= 1'b0;
				pcpi_ready_o <= 1'b1;
				pcpi_wr_o <= cfg_done_i | (mv_done_i & mv_wr_i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_done_i)
			pcpi_rd_o <= xword_t'(cfg_vl_i); // new vl
		else
			pcpi_rd_o <= mv_rd_i;
	end

	// units run one at a time
	assert property (@(posedge clk) disable iff (!resetn)
		$onehot0({cfg_done_i, mv_done_i, lsu_done_i}));

endmodule

// ==== hdl/rvv_move_unit.sv ====
`timescale 1ns/1ps
`include "rvv_params.svh"

module rvv_move_unit import rvv_pkg::*; (
	input  logic       clk,
	input  logic       resetn,
	input  logic       start_i,
	input  rvv_op_e    op_i,
	input  opnd_e      opnd_i,
	input  xword_t     insn_i,
	input  xword_t     rs1_i,
	input  vl_t        vl_i,
	input  sew_e       sew_i,
	input  lmul_t      lmul_i,
	output vreg_addr_t raddr_o,
	input  vreg_t      rdata_i,
	output vreg_addr_t waddr_o,
	output vreg_t      wdata_o,
	output logic       we_o,
	output logic       done_o,
	output logic       wr_o,
	output xword_t     rd_o
);
	localparam int VLEN_LOG = $clog2(`RVV_VLEN);

	typedef enum logic {mv_idle, mv_walk} mv_state_e;

	mv_state_e  state;
	vl_t        remain; // elements still to fill
	vreg_addr_t reg_idx;
	vreg_t      old_q; // old contents of the register holding the tail
	int         epr_log;
	vl_t        epr;
	xword_t     elem;
	vreg_t      splat;
	vreg_t      lane_mask;
	vreg_t      walk_data;
	vreg_t      sx_data;
	xword_t     xs_word;
	logic       last;

	function automatic vreg_t fill_mask(vl_t cnt, sew_e sew);
		int bits;
		bits = int'(cnt) << (int'(sew) + 3);
		if (bits >= `RVV_VLEN)
			return '1;
		return ~(vreg_t'('1) << bits);
	endfunction

	always_comb begin
		epr_log = VLEN_LOG - 3 - int'(sew_i);
		epr = vl_t'(1) << epr_log;
		if (state == mv_walk)
			raddr_o = insn_i[19:15] + reg_idx; // vs1 + offset
		else if (op_i == op_vmv_xs)
			raddr_o = insn_i[24:20];
		else if (op_i == op_vmv_v)
			raddr_o = insn_i[11:7] + vreg_addr_t'(vl_i >> epr_log);
		else
			raddr_o = insn_i[11:7];

		elem = (opnd_i == opnd_vi) ? {{27{insn_i[19]}}, insn_i[19:15]} : rs1_i;
		case (sew_i)
			sew_8: begin
				splat = {(`RVV_VLEN / 8){elem[7:0]}};
				sx_data = {rdata_i[`RVV_VLEN-1:8], rs1_i[7:0]};
				xs_word = {{24{rdata_i[7]}}, rdata_i[7:0]};
			end
			sew_16: begin
				splat = {(`RVV_VLEN / 16){elem[15:0]}};
				sx_data = {rdata_i[`RVV_VLEN-1:16], rs1_i[15:0]};
				xs_word = {{16{rdata_i[15]}}, rdata_i[15:0]};
			end
			default: begin
				splat = {(`RVV_VLEN / 32){elem}};
				sx_data = {rdata_i[`RVV_VLEN-1:32], rs1_i};
				xs_word = rdata_i[31:0];
			end
		endcase
		lane_mask = fill_mask(remain, sew_i);
		walk_data = (((opnd_i == opnd_vv) ? rdata_i : splat) & lane_mask) | (old_q & ~lane_mask);
		last = (remain <= epr) || (reg_idx == vreg_addr_t'((1 << lmul_i) - 1));
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= mv_idle;
			remain <= '0;
			reg_idx <= '0;
			we_o <= 1'b0;
			done_o <= 1'b0;
			wr_o <= 1'b0;
		end else begin
			we_o <= 1'b0;
			done_o <= 1'b0;
			wr_o <= 1'b0;
			case (state)
				mv_idle: begin
					if (start_i) begin
						case (op_i)
							op_vmv_xs: begin
								done_o <= 1'b1;
								wr_o <= 1'b1;
							end
							op_vmv_sx: begin
								done_o <= 1'b1;
								we_o <= (vl_i != '0);
							end
							op_vmv_v: begin
								state <= mv_walk;
								remain <= vl_i;
								reg_idx <= '0;
							end
							default: ;
						endcase
					end
				end
				default: begin
					we_o <= 1'b1; // one register per cycle
					if (last) begin
						done_o <= 1'b1;
						state <= mv_idle;
					end else begin
						remain <= remain - epr;
						reg_idx <= reg_idx + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mv_walk) begin
			wdata_o <= walk_data;
			waddr_o <= insn_i[11:7] + reg_idx;
		end else begin
			wdata_o <= sx_data;
			waddr_o <= insn_i[11:7];
			old_q <= rdata_i; // read before any write of the group
		end
		rd_o <= xs_word;
	end

endmodule

// ==== hdl/rvv_vcfg.sv ====
`timescale 1ns/1ps
`include "rvv_params.svh"

module rvv_vcfg import rvv_pkg::*; (
	input  logic    clk,
	input  logic    resetn,
	input  logic    start_i,
	input  rvv_op_e op_i,
	input  xword_t  insn_i,
	input  xword_t  rs1_i,
	input  xword_t  rs2_i,
	output logic    done_o,
	output vl_t     vl_o,
	output sew_e    sew_o,
	output lmul_t   lmul_o
);
	logic       vill;
	logic [2:0] new_sew;
	lmul_t      new_lmul;
	logic       bad_vtype;
	vl_t        vlmax;
	xword_t     avl;
	vl_t        new_vl;

	always_comb begin
		if (op_i == op_vsetvl) begin
			new_sew = rs2_i[5:3];
			new_lmul = rs2_i[2:0];
		end else begin
			new_sew = insn_i[25:23];
			new_lmul = insn_i[22:20];
		end
		// sew 64, fractional or reserved lmul, or vill requested
		bad_vtype = (new_sew > 3'b010) || new_lmul[2] || (op_i == op_vsetvl && rs2_i[31]);
		vlmax = vl_t'(`RVV_VLEN >> (new_sew + 3)) << new_lmul[1:0];
		if (op_i == op_vsetivli)
			avl = {27'd0, insn_i[19:15]}; // uimm5
		else if (insn_i[19:15] != 5'd0)
			avl = rs1_i;
		else if (insn_i[11:7] != 5'd0)
			avl = '1; // rd only, take vlmax
		else
			avl = xword_t'(vl_o);
		new_vl = (avl < xword_t'(vlmax)) ? vl_t'(avl) : vlmax;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vill <= 1'b1;
			vl_o <= '0;
			sew_o <= sew_8;
			lmul_o <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= start_i; // never stalls
			if (start_i) begin
				vill <= bad_vtype;
				vl_o <= bad_vtype ? '0 : new_vl;
				sew_o <= bad_vtype ? sew_8 : sew_e'(new_sew);
				lmul_o <= bad_vtype ? '0 : new_lmul;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!resetn)
		(vl_o <= vl_t'(`RVV_VLEN)) && (!vill || vl_o == '0));

endmodule

// ==== hdl/rvv_vregs.sv ====
`timescale 1ns/1ps
`include "rvv_params.svh"

module rvv_vregs import rvv_pkg::*; (
	input  logic       clk,
	input  vreg_addr_t raddr_a_i,
	output vreg_t      rdata_a_o,
	input  vreg_addr_t raddr_b_i,
	output vreg_t      rdata_b_o,
	input  logic       mv_we_i,
	input  vreg_addr_t mv_waddr_i,
	input  vreg_t      mv_wdata_i,
	input  logic       lsu_we_i,
	input  vreg_addr_t lsu_waddr_i,
	input  vreg_t      lsu_wdata_i
);
	vreg_t      regs [`RVV_NUM_VREGS];
	logic       we;
	vreg_addr_t waddr;
	vreg_t      wdata;

	// mover and lsu never write in the same cycle
	assign we = mv_we_i | lsu_we_i;
	assign waddr = mv_we_i ? mv_waddr_i : lsu_waddr_i;
	assign wdata = mv_we_i ? mv_wdata_i : lsu_wdata_i;

	always_ff @(posedge clk) begin
		if (we)
			regs[waddr] <= wdata;
	end

	assign rdata_a_o = regs[raddr_a_i]; // mover port
	assign rdata_b_o = regs[raddr_b_i]; // lsu port

	assert property (@(posedge clk) !(mv_we_i && lsu_we_i));

endmodule

// ==== lsu/rvv_lsu.sv ====
`timescale 1ns/1ps
`include "rvv_params.svh"

module rvv_lsu import rvv_pkg::*; (
	input  logic       clk,
	input  logic       resetn,
	input  logic       start_i,
	input  rvv_op_e    op_i,
	input  xword_t     insn_i,
	input  xword_t     rs1_i,
	input  vl_t        vl_i,
	output vreg_addr_t raddr_o,
	input  vreg_t      rdata_i,
	output vreg_addr_t waddr_o,
	output vreg_t      wdata_o,
	output logic       we_o,
	output logic       mem_req_o,
	output logic       mem_we_o,
	output xword_t     mem_addr_o,
	output xword_t     mem_wdata_o,
	output logic [3:0] mem_strb_o,
	input  xword_t     mem_rdata_i,
	input  logic       mem_done_i,
	output logic       done_o
);
	localparam int VLEN_LOG = $clog2(`RVV_VLEN);

	typedef enum logic [1:0] {ls_idle, ls_req, ls_wait, ls_fin} ls_state_e;

	ls_state_e  state;
	vl_t        cnt; // element index over the group
	vl_t        elem; // element index inside the register
	vreg_addr_t reg_idx;
	int         ew_log; // log2 of element bytes
	int         bit_pos;
	xword_t     addr;
	xword_t     ew_mask;
	logic [3:0] strb;
	xword_t     st_word;
	xword_t     ld_word;
	vreg_t      ld_merge;
	logic       is_load;
	logic       last_elem;
	logic       last_in_reg;

	assign is_load = (op_i == op_vload);
	assign raddr_o = insn_i[11:7] + reg_idx; // vd or vs3

	always_comb begin
		case (insn_i[14:12])
			3'b101: ew_log = 1;
			3'b110: ew_log = 2;
			default: ew_log = 0;
		endcase
		addr = rs1_i + (xword_t'(cnt) << ew_log);
		bit_pos = int'(elem) << (ew_log + 3);
		ew_mask = ~(xword_t'('1) << (8 << ew_log));
		case (ew_log)
			0: strb = 4'b0001 << addr[1:0];
			1: strb = 4'b0011 << addr[1:0];
			default: strb = 4'b1111;
		endcase
		// element moved to its byte lane in the word
		st_word = (xword_t'(rdata_i >> bit_pos) & ew_mask) << {addr[1:0], 3'b000};
		ld_word = (mem_rdata_i >> {addr[1:0], 3'b000}) & ew_mask;
		ld_merge = (rdata_i & ~(vreg_t'(ew_mask) << bit_pos)) | (vreg_t'(ld_word) << bit_pos);
		last_elem = (cnt == vl_i - 1'b1);
		last_in_reg = (elem == (vl_t'(1) << (VLEN_LOG - 3 - ew_log)) - 1'b1);
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ls_idle;
			cnt <= '0;
			elem <= '0;
			reg_idx <= '0;
			mem_req_o <= 1'b0;
			we_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			mem_req_o <= 1'b0;
			we_o <= 1'b0;
			done_o <= 1'b0;
			case (state)
				ls_idle: begin
					if (start_i) begin
						cnt <= '0;
						elem <= '0;
						reg_idx <= '0;
						state <= (vl_i == '0) ? ls_fin : ls_req; // vl 0 skips memory
					end
				end
				ls_req: begin
					mem_req_o <= 1'b1;
					state <= ls_wait;
				end
				ls_wait: begin
					if (mem_done_i) begin
						we_o <= is_load;
						cnt <= cnt + 1'b1;
						if (last_in_reg) begin
							elem <= '0;
							reg_idx <= reg_idx + 1'b1;
						end else begin
							elem <= elem + 1'b1;
						end
						state <= last_elem ? ls_fin : ls_req;
					end
				end
				default: begin
					done_o <= 1'b1;
					state <= ls_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ls_req) begin
			mem_we_o <= !is_load;
			mem_addr_o <= {addr[31:2], 2'b00};
			mem_wdata_o <= st_word;
			mem_strb_o <= strb;
		end
		waddr_o <= raddr_o;
		wdata_o <= ld_merge;
	end

	// one access in flight, its request held until done
	assert property (@(posedge clk) disable iff (!resetn)
		(state == ls_wait && !mem_done_i) |=>
			!mem_req_o && $stable(mem_addr_o) && $stable(mem_wdata_o));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module tb_rvv -o tb_rvv

./obj_dir/tb_rvv > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== testbench/tb_rvv.sv ====
`timescale 1ns/1ps

module tb_rvv import rvv_pkg::*;;
	localparam int TIMEOUT_CYCLES = 20000; // rows times 128 elements at 6 cycles, with margin

	logic       clk;
	logic       resetn;
	logic       pcpi_valid;
	xword_t     pcpi_insn, pcpi_rs1, pcpi_rs2;
	logic       pcpi_ready_o, pcpi_wait_o, pcpi_wr_o, pcpi_is_rvv_o;
	xword_t     pcpi_rd_o;
	xword_t     mem_rdata;
	logic       mem_done;
	logic       mem_req, mem_we;
	xword_t     mem_addr, mem_wdata;
	logic [3:0] mem_strb;
	int         cycles;

	// stimulus table
	xword_t row_insn[$], row_rs1[$], row_rs2[$], row_rd[$];
	logic   row_wr[$], row_has_rd[$], row_vec[$];

	rvv_coproc_top i_dut (
		.clk(clk), .resetn(resetn),
		.pcpi_valid_i(pcpi_valid), .pcpi_insn_i(pcpi_insn),
		.pcpi_rs1_i(pcpi_rs1), .pcpi_rs2_i(pcpi_rs2),
		.pcpi_ready_o(pcpi_ready_o), .pcpi_wait_o(pcpi_wait_o),
		.pcpi_wr_o(pcpi_wr_o), .pcpi_rd_o(pcpi_rd_o), .pcpi_is_rvv_o(pcpi_is_rvv_o),
		.mem_rdata_i(mem_rdata), .mem_done_i(mem_done),
		.mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata), .mem_strb_o(mem_strb)
	);

	tb_rvv_mem i_mem (
		.clk(clk), .mem_req_i(mem_req), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
		.mem_wdata_i(mem_wdata), .mem_strb_i(mem_strb),
		.mem_done_o(mem_done), .mem_rdata_o(mem_rdata)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the DUT did not finish the table within %0d cycles", cycles);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	// preload pattern, every address bit matters
	function automatic logic [7:0] pat_byte(int a);
		return 8'(a * 37 + (a >> 8) * 11 + 92);
	endfunction

	function automatic xword_t pat_word(int a);
		return {pat_byte(a + 3), pat_byte(a + 2), pat_byte(a + 1), pat_byte(a)};
	endfunction

	function automatic xword_t read_mem_word(int a);
		return {i_mem.mem[a + 3], i_mem.mem[a + 2], i_mem.mem[a + 1], i_mem.mem[a]};
	endfunction

	// instruction encoders, rs1 field x1, rd field x2
	function automatic xword_t vsetvli_insn(logic [10:0] zimm);
		return {1'b0, zimm, 5'd1, 3'b111, 5'd2, 7'b1010111};
	endfunction

	function automatic xword_t vsetivli_insn(logic [9:0] zimm, logic [4:0] uimm);
		return {2'b11, zimm, uimm, 3'b111, 5'd2, 7'b1010111};
	endfunction

	function automatic xword_t opv_insn(logic [5:0] f6, logic [4:0] vs2, logic [4:0] vs1,
			logic [2:0] f3, logic [4:0] vd);
		return {f6, 1'b1, vs2, vs1, f3, vd, 7'b1010111};
	endfunction

	function automatic xword_t mem_insn(logic store, logic [2:0] width, logic [4:0] vreg);
		return {7'b0000001, 5'd0, 5'd1, width, vreg, store ? 7'b0100111 : 7'b0000111};
	endfunction

	task automatic add_row(xword_t insn, xword_t rs1, xword_t rs2, logic wr, logic has_rd,
			xword_t rd, logic vec);
		row_insn.push_back(insn);
		row_rs1.push_back(rs1);
		row_rs2.push_back(rs2);
		row_wr.push_back(wr);
		row_has_rd.push_back(has_rd);
		row_rd.push_back(rd);
		row_vec.push_back(vec);
	endtask

	task automatic check_word(string name, xword_t got, xword_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	// called 5 ns after a rising edge
	task automatic run_row(int i);
		pcpi_insn = row_insn[i];
		pcpi_rs1 = row_rs1[i];
		pcpi_rs2 = row_rs2[i];
		pcpi_valid = 1'b1;
		#1;
		check_flag("pcpi_is_rvv_o", pcpi_is_rvv_o, row_vec[i]);
		if (row_vec[i]) begin
			do begin
				@(posedge clk);
				#5;
				if (!pcpi_ready_o)
					check_flag("pcpi_wait_o", pcpi_wait_o, 1'b1); // busy until ready
			end while (!pcpi_ready_o);
			check_flag("pcpi_wait_o", pcpi_wait_o, 1'b0);
			check_flag("pcpi_wr_o", pcpi_wr_o, row_wr[i]);
			if (row_has_rd[i])
				check_word("pcpi_rd_o", pcpi_rd_o, row_rd[i]);
			pcpi_valid = 1'b0;
			@(posedge clk);
			#5;
			check_flag("pcpi_ready_o", pcpi_ready_o, 1'b0); // one-cycle pulse
		end else begin
			@(posedge clk);
			#5;
			check_flag("pcpi_wait_o", pcpi_wait_o, 1'b0); // not taken
			check_flag("pcpi_ready_o", pcpi_ready_o, 1'b0);
			pcpi_valid = 1'b0;
		end
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		pcpi_valid = 1'b0;
		pcpi_insn = '0;
		pcpi_rs1 = '0;
		pcpi_rs2 = '0;
		cycles = 0;
		for (int a = 0; a < 2048; a++)
			i_mem.mem[a] = pat_byte(a);

		// configuration
		add_row({7'b1000000, 5'd3, 5'd1, 3'b111, 5'd2, 7'b1010111}, 7, 0, 1, 1, 7, 1);
		add_row(vsetivli_insn(10'h000, 5'd9), 0, 0, 1, 1, 9, 1);
		add_row(vsetvli_insn(11'h000), 20, 0, 1, 1, 16, 1); // e8 m1
		add_row(vsetvli_insn(11'h011), 5, 0, 1, 1, 5, 1); // e32 m2
		add_row(vsetvli_insn(11'h007), 20, 0, 1, 1, 0, 1); // mf2 is illegal
		// splat and scalar moves
		add_row(vsetvli_insn(11'h000), 16, 0, 1, 1, 16, 1);
		add_row(opv_insn(6'b010111, 5'd0, 5'd1, 3'b100, 5'd1), 32'h80, 0, 0, 0, 0, 1);
		add_row(opv_insn(6'b010000, 5'd1, 5'd0, 3'b010, 5'd2), 0, 0, 1, 1, 32'hFFFFFF80, 1);
		add_row(vsetvli_insn(11'h008), 8, 0, 1, 1, 8, 1); // e16
		add_row(opv_insn(6'b010000, 5'd0, 5'd1, 3'b110, 5'd2), 32'h1234, 0, 0, 0, 0, 1);
		add_row(opv_insn(6'b010000, 5'd2, 5'd0, 3'b010, 5'd2), 0, 0, 1, 1, 32'h1234, 1);
		add_row(opv_insn(6'b010111, 5'd0, 5'd29, 3'b011, 5'd3), 0, 0, 0, 0, 0, 1); // imm -3
		add_row(opv_insn(6'b010000, 5'd3, 5'd0, 3'b010, 5'd2), 0, 0, 1, 1, 32'hFFFFFFFD, 1);
		// partial store of bytes
		add_row(vsetvli_insn(11'h000), 5, 0, 1, 1, 5, 1);
		add_row(opv_insn(6'b010111, 5'd0, 5'd29, 3'b011, 5'd4), 0, 0, 0, 0, 0, 1);
		add_row(mem_insn(1'b1, 3'b000, 5'd4), 32'h100, 0, 0, 0, 0, 1);
		// word load and copy back out
		add_row(vsetvli_insn(11'h010), 4, 0, 1, 1, 4, 1);
		add_row(mem_insn(1'b0, 3'b110, 5'd5), 32'h200, 0, 0, 0, 0, 1);
		add_row(mem_insn(1'b1, 3'b110, 5'd5), 32'h300, 0, 0, 0, 0, 1);
		// vector copy of 3 words
		add_row(vsetvli_insn(11'h010), 3, 0, 1, 1, 3, 1);
		add_row(opv_insn(6'b010111, 5'd0, 5'd5, 3'b000, 5'd6), 0, 0, 0, 0, 0, 1);
		add_row(opv_insn(6'b010000, 5'd6, 5'd0, 3'b010, 5'd2), 0, 0, 1, 1, pat_word(32'h200), 1);
		add_row(mem_insn(1'b1, 3'b110, 5'd6), 32'h400, 0, 0, 0, 0, 1);
		add_row(32'h002081B3, 0, 0, 0, 0, 0, 0); // add x3, x1, x2

		repeat (2) @(posedge clk);
		#5;
		resetn = 1'b1;
		@(posedge clk);
		#5;
		for (int i = 0; i < row_insn.size(); i++)
			run_row(i);

		check_word("mem[0x100]", read_mem_word(32'h100), 32'hFDFDFDFD);
		check_word("mem[0x104]", read_mem_word(32'h104),
			{pat_byte(32'h107), pat_byte(32'h106), pat_byte(32'h105), 8'hFD});
		for (int k = 0; k < 4; k++)
			check_word($sformatf("mem[0x%0h]", 32'h300 + 4 * k),
				read_mem_word(32'h300 + 4 * k), pat_word(32'h200 + 4 * k));
		for (int k = 0; k < 3; k++)
			check_word($sformatf("mem[0x%0h]", 32'h400 + 4 * k),
				read_mem_word(32'h400 + 4 * k), pat_word(32'h200 + 4 * k));
		check_word("mem[0x40c]", read_mem_word(32'h40C), pat_word(32'h40C)); // past vl

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== testbench/tb_rvv_mem.sv ====
`timescale 1ns/1ps

module tb_rvv_mem import rvv_pkg::*; (
	input  logic       clk,
	input  logic       mem_req_i,
	input  logic       mem_we_i,
	input  xword_t     mem_addr_i,
	input  xword_t     mem_wdata_i,
	input  logic [3:0] mem_strb_i,
	output logic       mem_done_o,
	output xword_t     mem_rdata_o
);
	logic [7:0] mem [0:2047]; // byte array, filled by the testbench
	int         delay;
	int         base;

	initial begin
		void'($urandom(79));
		mem_done_o = 1'b0;
		mem_rdata_o = '0;
		forever begin
			@(posedge clk);
			#1; // request is a registered pulse, stable here
			if (mem_req_i) begin
				base = int'(mem_addr_i[10:0]) & ~3;
				delay = $urandom_range(4, 1);
				if (mem_we_i) begin
					for (int b = 0; b < 4; b++) begin
						if (mem_strb_i[b])
							mem[base + b] = mem_wdata_i[8*b +: 8];
					end
				end
				repeat (delay) @(posedge clk);
				#5;
				mem_rdata_o = {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
				mem_done_o = 1'b1;
				@(posedge clk);
				#5;
				mem_done_o = 1'b0;
			end
		end
	end

endmodule
